//--- axis_route_top.f
source/axis_route_pkg.sv
source/axis_route_cfg_if.sv
source/axis_route_regs.sv
source/axis_fan_out.sv
source/axis_fifo_sync.sv
source/axis_route_top.sv
bench/tb_clock_gen.sv
bench/axis_route_sva.sv
bench/axis_route_tb.sv

//--- bench/axis_route_sva.sv
`timescale 1ns/10ps

module axis_route_sva
  import axis_route_pkg::*;
(
  input logic                                 axis_clk,
  input logic                                 arst_n,
  input logic                                 s_axis_tvalid,
  input logic                                 s_axis_tready,
  input logic [DEST_WIDTH-1:0]                s_axis_tdest,
  input logic [NUM_PORTS-1:0]                 m_axis_tvalid,
  input logic [NUM_PORTS-1:0]                 m_axis_tready,
  input logic [NUM_PORTS*DATA_WIDTH-1:0]      m_axis_tdata,
  input logic [NUM_PORTS-1:0][DEST_WIDTH-1:0] route_map,
  input logic [NUM_PORTS-1:0]                 port_enable
);

  // failures so far, read by the testbench
  int assert_errors;

  initial begin
    assert_errors = 0;
  end

  ////////////////////////////////////////////////////////////////////////////
  // one beat in, at most one port out
  ////////////////////////////////////////////////////////////////////////////

  // a valid rises only after an input transfer, and on one port at most
  a_one_rise: assert property (@(posedge axis_clk) disable iff (!arst_n)
    $countones(m_axis_tvalid & ~$past(m_axis_tvalid)) <=
    ($past(s_axis_tvalid && s_axis_tready) ? 1 : 0))
    else begin
      assert_errors++;
      $error("output valid rose without a matching input transfer");
    end

  // disabled port always sinks the beat
  a_drop_ready: assert property (@(posedge axis_clk) disable iff (!arst_n)
    !port_enable[route_map[s_axis_tdest]] |-> s_axis_tready)
    else begin
      assert_errors++;
      $error("input not ready while its mapped port is disabled");
    end

  ////////////////////////////////////////////////////////////////////////////
  // output stream rule per port
  ////////////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    // valid holds with stable data until taken
    a_hold: assert property (@(posedge axis_clk) disable iff (!arst_n)
      (m_axis_tvalid[p] && !m_axis_tready[p]) |=>
      (m_axis_tvalid[p] && $stable(m_axis_tdata[p*DATA_WIDTH +: DATA_WIDTH])))
      else begin
        assert_errors++;
        $error("output valid dropped or data changed before ready");
      end
  end

endmodule

// checker sits on the top level, map and mask taken from the config interface
bind axis_route_top axis_route_sva u_sva (
  .axis_clk      (axis_clk),
  .arst_n        (arst_n),
  .s_axis_tvalid (s_axis_tvalid),
  .s_axis_tready (s_axis_tready),
  .s_axis_tdest  (s_axis_tdest),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tready (m_axis_tready),
  .m_axis_tdata  (m_axis_tdata),
  .route_map     (cfg_if.route_map),
  .port_enable   (cfg_if.port_enable)
);

//--- bench/axis_route_tb.sv
`timescale 1ns/10ps

module axis_route_tb
  import axis_route_pkg::*;
();

  localparam int BEATS_PER_TEST = 200;
  localparam int WAIT_LIMIT     = 1000;

  logic                            axis_clk;
  logic                            arst_n;
  logic                            s_axis_tvalid;
  logic                            s_axis_tready;
  logic [DATA_WIDTH-1:0]           s_axis_tdata;
  logic [DEST_WIDTH-1:0]           s_axis_tdest;
  logic [NUM_PORTS-1:0]            m_axis_tvalid;
  logic [NUM_PORTS-1:0]            m_axis_tready;
  logic [NUM_PORTS*DATA_WIDTH-1:0] m_axis_tdata;
  logic                            cfg_wr;
  logic [CFG_ADDR_WIDTH-1:0]       cfg_addr;
  logic [CFG_DATA_WIDTH-1:0]       cfg_wdata;
  logic [CFG_DATA_WIDTH-1:0]       cfg_rdata;

  // reference copy of the register state
  logic [DEST_WIDTH-1:0] ref_map [NUM_PORTS];
  logic [NUM_PORTS-1:0]  ref_en;
  int                    ref_drops;

  // expected beats per output port, oldest first
  logic [DATA_WIDTH-1:0] exp_q [NUM_PORTS][$];

  logic [31:0] lfsr = 32'h05c76692;
  logic        rand_ready;
  string       test_name;
  int          errors;
  int          errors_at_start;
  int          tests_run;
  int          tests_failed;

  tb_clock_gen u_clk (
    .axis_clk (axis_clk),
    .arst_n   (arst_n)
  );

  axis_route_top i_dut (
    .axis_clk      (axis_clk),
    .arst_n        (arst_n),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tdest  (s_axis_tdest),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .cfg_wr        (cfg_wr),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .cfg_rdata     (cfg_rdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // physical port for a dest, -1 when that port is off
  function automatic int expected_port(input logic [DEST_WIDTH-1:0] dest);
    int port;
    port = int'(ref_map[dest]);
    return ref_en[port] ? port : -1;
  endfunction

  function automatic logic [CFG_DATA_WIDTH-1:0] ref_read(input int addr);
    if (addr <= int'(ADDR_MAP3)) return CFG_DATA_WIDTH'(ref_map[addr]);
    if (addr == int'(ADDR_ENABLE)) return CFG_DATA_WIDTH'(ref_en);
    if (addr == int'(ADDR_DROPS)) return CFG_DATA_WIDTH'(ref_drops % 256);
    return '0;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks and bus tasks
  ////////////////////////////////////////////////////////////////////////////

  // scoreboard mismatches plus bound assertion failures
  function automatic int total_errors();
    return errors + i_dut.u_sva.assert_errors;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s during %s", why, test_name);
    $display("Test failed");
    $finish;
  endtask

  // rising edge, then new random readies when enabled
  task automatic next_cycle();
    @(posedge axis_clk);
    if (rand_ready) begin
      m_axis_tready <= NUM_PORTS'(rand_bits(NUM_PORTS));
    end
  endtask

  task automatic idle_cycle();
    next_cycle();
    s_axis_tvalid <= 1'b0;
  endtask

  task automatic write_reg(input int addr, input logic [CFG_DATA_WIDTH-1:0] data);
    @(posedge axis_clk);
    cfg_wr    <= 1'b1;
    cfg_addr  <= CFG_ADDR_WIDTH'(addr);
    cfg_wdata <= data;
    @(posedge axis_clk);
    cfg_wr <= 1'b0;
    // mirror the write
    if (addr <= int'(ADDR_MAP3)) ref_map[addr] = data[DEST_WIDTH-1:0];
    else if (addr == int'(ADDR_ENABLE)) ref_en = data[NUM_PORTS-1:0];
    else if (addr == int'(ADDR_DROPS)) ref_drops = 0;
  endtask

  task automatic read_reg(input int addr, output logic [CFG_DATA_WIDTH-1:0] data);
    @(posedge axis_clk);
    cfg_addr <= CFG_ADDR_WIDTH'(addr);
    @(negedge axis_clk);
    data = cfg_rdata;
  endtask

  // offer one beat, hold until taken, then record what should come out
  task automatic send_beat(input logic [DATA_WIDTH-1:0] data,
                           input logic [DEST_WIDTH-1:0] dest);
    int cnt;
    int port;
    cnt = 0;
    next_cycle();
    s_axis_tvalid <= 1'b1;
    s_axis_tdata  <= data;
    s_axis_tdest  <= dest;
    @(negedge axis_clk);
    while (!s_axis_tready && cnt < WAIT_LIMIT) begin
      next_cycle();
      @(negedge axis_clk);
      cnt++;
    end
    if (!s_axis_tready) abort_run("input stream never became ready");
    port = expected_port(dest);
    if (port < 0) ref_drops++;
    else exp_q[port].push_back(data);
  endtask

  task automatic wait_drain();
    int cnt;
    int left;
    cnt = 0;
    left = 1;
    while (left != 0 && cnt < WAIT_LIMIT) begin
      next_cycle();
      @(negedge axis_clk);
      left = 0;
      for (int p = 0; p < NUM_PORTS; p++) left += exp_q[p].size();
      cnt++;
    end
    if (left != 0) abort_run("output ports did not deliver all expected beats");
  endtask

  task automatic run_random(input int count);
    for (int i = 0; i < count; i++) begin
      send_beat(rand_bits(DATA_WIDTH), DEST_WIDTH'(rand_bits(DEST_WIDTH)));
      // sometimes leave a gap
      if (rand_bits(1) != 0) idle_cycle();
    end
    idle_cycle();
    wait_drain();
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = total_errors();
  endtask

  task automatic end_test();
    int now_errors;
    now_errors = total_errors();
    tests_run++;
    if (now_errors == errors_at_start) begin
      $display("%s: ok", test_name);
    end else begin
      $display("%s: %0d errors", test_name, now_errors - errors_at_start);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output monitor and scoreboard
  ////////////////////////////////////////////////////////////////////////////

  // negedge view, transfer happens on the next rising edge
  always @(negedge axis_clk) begin
    if (arst_n) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (m_axis_tvalid[p] && m_axis_tready[p]) begin
          if (exp_q[p].size() == 0) begin
            $display("unexpected beat on port %0d during %s", p, test_name);
            errors++;
          end else begin
            check_value($sformatf("%s port %0d", test_name, p), exp_q[p].pop_front(),
                        m_axis_tdata[p*DATA_WIDTH +: DATA_WIDTH]);
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [CFG_DATA_WIDTH-1:0] rd;
    int cnt;
    int dest;
    int accepted;
    s_axis_tvalid <= 1'b0;
    s_axis_tdata  <= '0;
    s_axis_tdest  <= '0;
    m_axis_tready <= '0;
    cfg_wr        <= 1'b0;
    cfg_addr      <= '0;
    cfg_wdata     <= '0;
    for (int i = 0; i < NUM_PORTS; i++) ref_map[i] = DEST_WIDTH'(i);
    ref_en = 4'hF;
    ref_drops = 0;
    rand_ready = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    test_name = "reset";
    cnt = 0;
    while (arst_n !== 1'b1 && cnt < 20) begin
      @(posedge axis_clk);
      cnt++;
    end
    if (arst_n !== 1'b1) abort_run("reset was never released");

    // register defaults and idle outputs
    start_test("reset_values");
    for (int a = 0; a < 8; a++) begin
      read_reg(a, rd);
      check_value($sformatf("reset_values addr %0d", a), ref_read(a), rd);
    end
    check_value("reset_values tvalid", '0, m_axis_tvalid);
    end_test();

    start_test("identity_map");
    rand_ready = 1'b1;
    run_random(BEATS_PER_TEST);
    end_test();

    // permutation 0->2 1->0 2->3 3->1
    start_test("permuted_map");
    write_reg(0, 8'd2);
    write_reg(1, 8'd0);
    write_reg(2, 8'd3);
    write_reg(3, 8'd1);
    run_random(BEATS_PER_TEST);
    end_test();

    // ports 1 and 3 off
    start_test("disabled_ports");
    write_reg(ADDR_ENABLE, 8'h05);
    run_random(BEATS_PER_TEST);
    read_reg(ADDR_DROPS, rd);
    check_value("disabled_ports count", ref_read(ADDR_DROPS), rd);
    write_reg(ADDR_DROPS, 8'h00);
    read_reg(ADDR_DROPS, rd);
    check_value("disabled_ports clear", '0, rd);
    write_reg(ADDR_ENABLE, 8'h0F);
    end_test();

    // fill port 2 with its ready held low
    start_test("fifo_full");
    rand_ready = 1'b0;
    dest = 0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (ref_map[i] == 2'd2) dest = i;
    end
    @(posedge axis_clk);
    m_axis_tready <= 4'b1011;
    accepted = 0;
    for (int n = 0; n < FIFO_DEPTH + 4; n++) begin
      next_cycle();
      s_axis_tvalid <= 1'b1;
      s_axis_tdata  <= rand_bits(DATA_WIDTH);
      s_axis_tdest  <= DEST_WIDTH'(dest);
      @(negedge axis_clk);
      if (!s_axis_tready) break;
      exp_q[2].push_back(s_axis_tdata);
      accepted++;
    end
    check_value("fifo_full accepted", FIFO_DEPTH, accepted);
    idle_cycle();
    m_axis_tready <= '1;
    wait_drain();
    end_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic axis_clk,
  output logic arst_n
);

  // 40 ns period, half period 20 ns
  initial begin
    axis_clk = 1'b0;
    forever begin
      #20 axis_clk = ~axis_clk;
    end
  end

  // reset held over the first 3 rising edges
  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge axis_clk);
    arst_n <= 1'b1;
  end

endmodule

//--- source/axis_fan_out.sv
`timescale 1ns/10ps

module axis_fan_out
  import axis_route_pkg::*;
(
  // input stream
  input  logic                            s_axis_tvalid,
  output logic                            s_axis_tready,
  input  logic [DATA_WIDTH-1:0]           s_axis_tdata,
  input  logic [DEST_WIDTH-1:0]           s_axis_tdest,

  // per-port write side of the fifos
  output logic [NUM_PORTS-1:0]            fan_valid,
  input  logic [NUM_PORTS-1:0]            fan_ready,
  output logic [NUM_PORTS*DATA_WIDTH-1:0] fan_data,

  // map, mask in and drops out
  axis_route_cfg_if.fan                   cfg
);

  // physical port after remap
  logic [DEST_WIDTH-1:0] port_sel;

  // mapped port enabled
  logic port_on;

  // one-hot valid before the enable gate
  logic [NUM_PORTS-1:0] valid_onehot;

  ////////////////////////////////////////////////////////////////////////////
  // destination lookup
  ////////////////////////////////////////////////////////////////////////////

  // logical dest through the remap table
  assign port_sel = cfg.route_map[s_axis_tdest];
  assign port_on  = cfg.port_enable[port_sel];

  ////////////////////////////////////////////////////////////////////////////
  // steering
  ////////////////////////////////////////////////////////////////////////////

  // single valid bit at the selected port
  assign valid_onehot = {{(NUM_PORTS-1){1'b0}}, s_axis_tvalid} << port_sel;

  // nothing goes out on a disabled port
  assign fan_valid = port_on ? valid_onehot : '0;

  // data copied to every port, valid picks the one
  assign fan_data = {NUM_PORTS{s_axis_tdata}};

  // enabled port stalls on its fifo, disabled port sinks at once
  assign s_axis_tready = port_on ? fan_ready[port_sel] : 1'b1;

  ////////////////////////////////////////////////////////////////////////////
  // drop report
  ////////////////////////////////////////////////////////////////////////////

  // ready is high here, so valid alone marks the transfer
  assign cfg.drop_pulse = s_axis_tvalid & ~port_on;
  assign cfg.drop_port  = port_sel;

endmodule

//--- source/axis_fifo_sync.sv
`timescale 1ns/10ps

module axis_fifo_sync
  import axis_route_pkg::*;
(
  input  logic                  axis_clk,
  input  logic                  arst_n,

  // write side
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic [DATA_WIDTH-1:0] s_axis_tdata,

  // read side
  output logic                  m_axis_tvalid,
  input  logic                  m_axis_tready,
  output logic [DATA_WIDTH-1:0] m_axis_tdata
);

  // storage, payload only so no reset
  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  // pointers carry one extra wrap bit
  logic [FIFO_ADDR_WIDTH:0] wr_ptr;
  logic [FIFO_ADDR_WIDTH:0] rd_ptr;

  // status
  logic full;
  logic empty;

  // transfer strobes
  logic wr_en;
  logic rd_en;

  ////////////////////////////////////////////////////////////////////////////
  // status flags
  ////////////////////////////////////////////////////////////////////////////

  // same index, wrap bits differ
  assign full = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                (wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);

  // pointers fully equal
  assign empty = (wr_ptr == rd_ptr);

  // a full fifo still takes a beat while the head is popped
  assign s_axis_tready = ~full | m_axis_tready;
  assign m_axis_tvalid = ~empty;

  assign wr_en = s_axis_tvalid & s_axis_tready;
  assign rd_en = m_axis_tvalid & m_axis_tready;

  ////////////////////////////////////////////////////////////////////////////
  // pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge axis_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // memory
  ////////////////////////////////////////////////////////////////////////////

  // write at the tail
  always_ff @(posedge axis_clk) begin
    if (wr_en) begin
      mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= s_axis_tdata;
    end
  end

  // head shown directly, visible the cycle after the write
  assign m_axis_tdata = mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];

endmodule

//--- source/axis_route_cfg_if.sv
`timescale 1ns/10ps

interface axis_route_cfg_if
  import axis_route_pkg::*;
();

  // remap table, physical port per logical dest
  logic [NUM_PORTS-1:0][DEST_WIDTH-1:0] route_map;

  // one bit per physical port
  logic [NUM_PORTS-1:0] port_enable;

  // drop event back to the counter
  logic drop_pulse;
  logic [DEST_WIDTH-1:0] drop_port;

  // register block side
  modport regs (
    output route_map,
    output port_enable,
    input  drop_pulse,
    input  drop_port
  );

  // fan-out side
  modport fan (
    input  route_map,
    input  port_enable,
    output drop_pulse,
    output drop_port
  );

endinterface

//--- source/axis_route_pkg.sv
package axis_route_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // stream and port sizes
  ////////////////////////////////////////////////////////////////////////////

  // four physical output ports
  localparam int NUM_PORTS = 4;

  // beat payload and destination index
  localparam int DATA_WIDTH = 32;
  localparam int DEST_WIDTH = 2;

  // per-port buffering
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);

  ////////////////////////////////////////////////////////////////////////////
  // configuration bus
  ////////////////////////////////////////////////////////////////////////////

  localparam int CFG_ADDR_WIDTH = 3;
  localparam int CFG_DATA_WIDTH = 8;

  // remap entries, one per logical destination
  localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_MAP0 = 3'd0;
  localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_MAP1 = 3'd1;
  localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_MAP2 = 3'd2;
  localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_MAP3 = 3'd3;

  // port enable mask, bit p for port p
  localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_ENABLE = 3'd4;

  // drop counter, write clears
  localparam logic [CFG_ADDR_WIDTH-1:0] ADDR_DROPS = 3'd5;

  // all ports on out of reset
  localparam logic [NUM_PORTS-1:0] ENABLE_RESET = 4'hF;

endpackage

//--- source/axis_route_regs.sv
`timescale 1ns/10ps

module axis_route_regs
  import axis_route_pkg::*;
(
  input  logic                      axis_clk,
  input  logic                      arst_n,
  input  logic                      cfg_wr,
  input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr,
  input  logic [CFG_DATA_WIDTH-1:0] cfg_wdata,
  output logic [CFG_DATA_WIDTH-1:0] cfg_rdata,
  axis_route_cfg_if.regs            cfg
);

  // register state
  logic [NUM_PORTS-1:0][DEST_WIDTH-1:0] map_q;
  logic [NUM_PORTS-1:0]                 enable_q;
  logic [CFG_DATA_WIDTH-1:0]            drop_cnt;

  // decoded strobes
  logic clr_drops;
  logic drop_hit;

  ////////////////////////////////////////////////////////////////////////////
  // remap table and enable mask
  ////////////////////////////////////////////////////////////////////////////

  // identity map out of reset, new values seen from next beat
  always_ff @(posedge axis_clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_PORTS; i++) begin
        map_q[i] <= DEST_WIDTH'(i);
      end
      enable_q <= ENABLE_RESET;
    end else if (cfg_wr) begin
      case (cfg_addr)
        ADDR_MAP0: map_q[0] <= cfg_wdata[DEST_WIDTH-1:0];
        ADDR_MAP1: map_q[1] <= cfg_wdata[DEST_WIDTH-1:0];
        ADDR_MAP2: map_q[2] <= cfg_wdata[DEST_WIDTH-1:0];
        ADDR_MAP3: map_q[3] <= cfg_wdata[DEST_WIDTH-1:0];
        ADDR_ENABLE: enable_q <= cfg_wdata[NUM_PORTS-1:0];
        // 5 handled by the counter, 6 and 7 ignored
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // drop counter
  ////////////////////////////////////////////////////////////////////////////

  assign clr_drops = cfg_wr && (cfg_addr == ADDR_DROPS);

  // only a disabled port can report a drop
  assign drop_hit = cfg.drop_pulse & ~enable_q[cfg.drop_port];

  // 8 bit wrap, clear wins over a same cycle drop
  always_ff @(posedge axis_clk or negedge arst_n) begin
    if (!arst_n) begin
      drop_cnt <= '0;
    end else if (clr_drops) begin
      drop_cnt <= '0;
    end else if (drop_hit) begin
      drop_cnt <= drop_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////

  // combinational, no read side effects
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      ADDR_MAP0: cfg_rdata[DEST_WIDTH-1:0] = map_q[0];
      ADDR_MAP1: cfg_rdata[DEST_WIDTH-1:0] = map_q[1];
      ADDR_MAP2: cfg_rdata[DEST_WIDTH-1:0] = map_q[2];
      ADDR_MAP3: cfg_rdata[DEST_WIDTH-1:0] = map_q[3];
      ADDR_ENABLE: cfg_rdata[NUM_PORTS-1:0] = enable_q;
      ADDR_DROPS: cfg_rdata = drop_cnt;
      // unused addresses read zero
      default: cfg_rdata = '0;
    endcase
  end

  // config state out to the fan-out
  assign cfg.route_map   = map_q;
  assign cfg.port_enable = enable_q;

endmodule

//--- source/axis_route_top.sv
`timescale 1ns/10ps

module axis_route_top
  import axis_route_pkg::*;
(
  input  logic                            axis_clk,
  input  logic                            arst_n,

  // input stream
  input  logic                            s_axis_tvalid,
  output logic                            s_axis_tready,
  input  logic [DATA_WIDTH-1:0]           s_axis_tdata,
  input  logic [DEST_WIDTH-1:0]           s_axis_tdest,

  // output streams, port p at bits 32p up
  output logic [NUM_PORTS-1:0]            m_axis_tvalid,
  input  logic [NUM_PORTS-1:0]            m_axis_tready,
  output logic [NUM_PORTS*DATA_WIDTH-1:0] m_axis_tdata,

  // register access
  input  logic                            cfg_wr,
  input  logic [CFG_ADDR_WIDTH-1:0]       cfg_addr,
  input  logic [CFG_DATA_WIDTH-1:0]       cfg_wdata,
  output logic [CFG_DATA_WIDTH-1:0]       cfg_rdata
);

  // fan-out to fifo write side
  logic [NUM_PORTS-1:0]            fan_valid;
  logic [NUM_PORTS-1:0]            fan_ready;
  logic [NUM_PORTS*DATA_WIDTH-1:0] fan_data;

  // map, mask and drop events
  axis_route_cfg_if cfg_if ();

  ////////////////////////////////////////////////////////////////////////////
  // configuration
  ////////////////////////////////////////////////////////////////////////////

  axis_route_regs u_regs (
    .axis_clk  (axis_clk),
    .arst_n    (arst_n),
    .cfg_wr    (cfg_wr),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .cfg       (cfg_if.regs)
  );

  ////////////////////////////////////////////////////////////////////////////
  // routing
  ////////////////////////////////////////////////////////////////////////////

  axis_fan_out u_fan_out (
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tdest  (s_axis_tdest),
    .fan_valid     (fan_valid),
    .fan_ready     (fan_ready),
    .fan_data      (fan_data),
    .cfg           (cfg_if.fan)
  );

  // one fifo per output port
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    axis_fifo_sync u_fifo (
      .axis_clk      (axis_clk),
      .arst_n        (arst_n),
      .s_axis_tvalid (fan_valid[p]),
      .s_axis_tready (fan_ready[p]),
      .s_axis_tdata  (fan_data[p*DATA_WIDTH +: DATA_WIDTH]),
      .m_axis_tvalid (m_axis_tvalid[p]),
      .m_axis_tready (m_axis_tready[p]),
      .m_axis_tdata  (m_axis_tdata[p*DATA_WIDTH +: DATA_WIDTH])
    );
  end

endmodule
